//--- cam_cfg.svh
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// Settling time of the sensor after reset, in clk cycles
`define CAM_POWERUP_CYCLES 1000000

// Register table size
`define CAM_REG_NUM 48
`define CAM_IDX_W 6

// SCCB device address with the write bit
`define CAM_DEV_WR_ID 8'h78

// One bus transfer carries one byte
`define CAM_BYTE_W 8

`endif

//--- cam_pkg.sv
`default_nettype none
`include "cam_cfg.svh"

package cam_pkg;

    typedef enum logic [1:0] {
        ST_WAIT  = 2'd0, // Power-up settling
        ST_IDLE  = 2'd1,
        ST_WREQ  = 2'd2, // Issue one byte request
        ST_WRITE = 2'd3  // Byte outstanding at the master
    } seq_state_t;

    typedef struct packed {
        logic stop;
        logic start;
        logic read;      // Master supports it, never set here
        logic write;
    } sccb_cmd_t;

    typedef struct packed {
        sccb_cmd_t              cmd;
        logic [`CAM_BYTE_W-1:0] data;
    } sccb_xfer_t;

    typedef struct packed {
        logic [2*`CAM_BYTE_W-1:0] addr; // Sensor register address
        logic [`CAM_BYTE_W-1:0]   value;
    } reg_entry_t;

endpackage

`default_nettype wire

//--- cam_reg_rom.sv
`default_nettype none
`include "cam_cfg.svh"

module cam_reg_rom
    import cam_pkg::*;
(
    input  logic [`CAM_IDX_W-1:0] idx,
    output reg_entry_t            entry
);

    // 24 MHz input clock, PLL setup and 1280x720 DVP output
    always_comb begin
        case (idx)
            6'd0  : entry = 24'h3103_11; // Clock from pad
            6'd1  : entry = 24'h3008_82; // Software reset
            6'd2  : entry = 24'h3008_42; // Software power down
            6'd3  : entry = 24'h3103_03; // Clock from PLL
            6'd4  : entry = 24'h3017_ff; // Sync and high data pins enabled
            6'd5  : entry = 24'h3018_ff; // Low data pins enabled
            6'd6  : entry = 24'h3034_1a;
            6'd7  : entry = 24'h3037_13; // PLL root and pre-divider
            6'd8  : entry = 24'h3108_01; // PCLK and SCLK dividers
            6'd9  : entry = 24'h302d_60; // System control
            6'd10 : entry = 24'h3810_00; // H offset high
            6'd11 : entry = 24'h3811_10; // H offset low
            6'd12 : entry = 24'h3812_00; // V offset high
            6'd13 : entry = 24'h3000_00; // Enable blocks
            6'd14 : entry = 24'h3004_ff; // Enable clocks
            6'd15 : entry = 24'h300e_58; // DVP on, MIPI off
            6'd16 : entry = 24'h302e_00;
            6'd17 : entry = 24'h4300_61; // RGB565 output
            6'd18 : entry = 24'h501f_01; // ISP format RGB
            6'd19 : entry = 24'h440e_00;
            6'd20 : entry = 24'h3008_02; // Wake up from standby
            6'd21 : entry = 24'h3035_21; // PLL
            6'd22 : entry = 24'h3036_69; // PLL multiplier
            6'd23 : entry = 24'h3820_47; // Flip
            6'd24 : entry = 24'h3821_01; // No mirror
            6'd25 : entry = 24'h3814_31; // X increment
            6'd26 : entry = 24'h3815_31; // Y increment
            6'd27 : entry = 24'h3800_00; // H start
            6'd28 : entry = 24'h3801_00;
            6'd29 : entry = 24'h3802_00; // V start
            6'd30 : entry = 24'h3803_fa;
            6'd31 : entry = 24'h3804_0a; // H end
            6'd32 : entry = 24'h3805_3f;
            6'd33 : entry = 24'h3806_06; // V end
            6'd34 : entry = 24'h3807_a9;
            6'd35 : entry = 24'h3808_05; // Output width 1280
            6'd36 : entry = 24'h3809_00;
            6'd37 : entry = 24'h380a_02; // Output height 720
            6'd38 : entry = 24'h380b_d0;
            6'd39 : entry = 24'h380c_07; // Total line length
            6'd40 : entry = 24'h380d_64;
            6'd41 : entry = 24'h380e_02; // Total frame height
            6'd42 : entry = 24'h380f_e4;
            6'd43 : entry = 24'h3813_04; // V offset low
            6'd44 : entry = 24'h3824_04; // PCLK manual divider
            6'd45 : entry = 24'h4740_20; // VSYNC polarity
            6'd46 : entry = 24'h503d_00; // Test pattern off
            6'd47 : entry = 24'h4741_00;
            default: entry = '0;         // Past the end of the table
        endcase
    end

endmodule

`default_nettype wire

//--- cam_power_wait.sv
`default_nettype none
`include "cam_cfg.svh"

module cam_power_wait #(
    parameter int POWERUP_CYCLES = `CAM_POWERUP_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    output logic ready
);

    localparam int CNT_W = (POWERUP_CYCLES > 1) ? $clog2(POWERUP_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(POWERUP_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic             cnt_end;

    assign cnt_end = (cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            ready <= 1'b0;
        end else if (cnt_end) begin
            ready <= 1'b1;                 // Sticky until the next reset
        end else begin
            cnt   <= cnt + CNT_W'(1);      // Holds once the last count is hit
        end
    end

endmodule

`default_nettype wire

//--- cam_config_seq.sv
`default_nettype none
`include "cam_cfg.svh"

module cam_config_seq
    import cam_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ready,
    input  logic                  done,
    input  reg_entry_t            entry,
    output logic [`CAM_IDX_W-1:0] idx,
    output logic                  req,
    output sccb_xfer_t            xfer,
    output logic                  config_done
);

    localparam logic [`CAM_IDX_W-1:0] LAST_IDX = `CAM_IDX_W'(`CAM_REG_NUM - 1);

    seq_state_t state;
    seq_state_t state_n;
    logic [1:0] byte_cnt;       // Which of the four bytes of an entry
    logic       byte_done;
    logic       entry_done;
    logic       last_entry;
    sccb_xfer_t next_xfer;

    // Done only counts while a byte is outstanding
    assign byte_done  = (state == ST_WRITE) && done;
    assign entry_done = byte_done && (byte_cnt == 2'd3);
    assign last_entry = (idx == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_WAIT;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            ST_WAIT: begin
                if (ready) begin
                    state_n = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (!config_done) begin
                    state_n = ST_WREQ;     // Parks here once the table is done
                end
            end
            ST_WREQ: begin
                state_n = ST_WRITE;
            end
            ST_WRITE: begin
                if (entry_done) begin
                    state_n = ST_IDLE;
                end else if (byte_done) begin
                    state_n = ST_WREQ;
                end
            end
            default: state_n = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= 2'd0;
        end else if (byte_done) begin
            byte_cnt <= byte_cnt + 2'd1;   // Wraps to 0 after the data byte
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx         <= '0;
            config_done <= 1'b0;
        end else if (entry_done) begin
            if (last_entry) begin
                config_done <= 1'b1;
            end else begin
                idx <= idx + `CAM_IDX_W'(1);
            end
        end
    end

    // Frame the current entry byte by byte
    always_comb begin
        next_xfer           = '0;
        next_xfer.cmd.write = 1'b1;
        case (byte_cnt)
            2'd0: begin
                next_xfer.cmd.start = 1'b1;
                next_xfer.data      = `CAM_DEV_WR_ID;
            end
            2'd1: next_xfer.data = entry.addr[2*`CAM_BYTE_W-1:`CAM_BYTE_W];
            2'd2: next_xfer.data = entry.addr[`CAM_BYTE_W-1:0];
            default: begin
                next_xfer.cmd.stop = 1'b1;
                next_xfer.data     = entry.value;
            end
        endcase
    end

    // One-cycle request, payload is zero outside it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req  <= 1'b0;
            xfer <= '0;
        end else if (state == ST_WREQ) begin
            req  <= 1'b1;
            xfer <= next_xfer;
        end else begin
            req  <= 1'b0;
            xfer <= '0;
        end
    end

endmodule

`default_nettype wire

//--- cam_config.sv
`default_nettype none
`include "cam_cfg.svh"

module cam_config
    import cam_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       done,        // From the SCCB byte master
    output logic       req,
    output sccb_xfer_t xfer,
    output logic       config_done
);

    logic                  ready;
    logic [`CAM_IDX_W-1:0] idx;
    reg_entry_t            entry;

    cam_power_wait u_power_wait (
        .clk   (clk),
        .rst_n (rst_n),
        .ready (ready)
    );

    cam_config_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .done        (done),
        .entry       (entry),
        .idx         (idx),
        .req         (req),
        .xfer        (xfer),
        .config_done (config_done)
    );

    cam_reg_rom u_rom (
        .idx   (idx),
        .entry (entry)
    );

endmodule

`default_nettype wire

//--- tb_cam_tasks.svh
`ifndef TB_CAM_TASKS_SVH
`define TB_CAM_TASKS_SVH

task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped");
endtask

task automatic check_equal(input string test_name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        fail_now($sformatf("MISMATCH %s: %s expected %0h actual %0h",
                           test_name, what, expected, actual));
    end
endtask

function automatic int pick_delay();
    if (random_delay) begin
        return int'($unsigned($random(seed)) % 16);  // 0 to 15 cycles
    end
    return 1;
endfunction

// Four bytes per register write with flags stop, start, read, write
function automatic sccb_xfer_t expected_xfer(input int entry_num, input int byte_num);
    sccb_xfer_t  x;
    logic [23:0] e;
    e           = EXP_TABLE[entry_num[`CAM_IDX_W-1:0]];
    x           = '0;
    x.cmd.write = 1'b1;
    if (byte_num == 0) begin
        x.cmd.start = 1'b1;
        x.data      = `CAM_DEV_WR_ID;
    end else if (byte_num == 1) begin
        x.data = e[23:16];
    end else if (byte_num == 2) begin
        x.data = e[15:8];
    end else begin
        x.cmd.stop = 1'b1;
        x.data     = e[7:0];
    end
    return x;
endfunction

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic apply_reset(input string test_name);
    next_cycle();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) begin
        next_cycle();
        check_equal(test_name, "req in reset", 32'd0, 32'(req));
        check_equal(test_name, "xfer in reset", 32'd0, 32'(xfer));
        check_equal(test_name, "config_done in reset", 32'd0, 32'(config_done));
    end
    rst_n = 1'b1;
    got_q.delete();
endtask

// First req is due power-up plus 3 cycles after release
task automatic wait_first_req(input string test_name);
    int cycles;
    cycles = 0;
    while (!req) begin
        if (cycles > POWERUP + 16) begin
            fail_now($sformatf("%s: no req after the power-up wait", test_name));
        end
        next_cycle();
        cycles++;
        check_equal(test_name, "config_done during power-up", 32'd0, 32'(config_done));
    end
    check_equal(test_name, "cycles to first req", 32'(POWERUP + 3), 32'(cycles));
endtask

task automatic wait_config_done(input string test_name, input int limit);
    int cycles;
    cycles = 0;
    while (!config_done) begin
        if (cycles == limit) begin
            fail_now($sformatf("%s: config_done never rose", test_name));
        end
        next_cycle();
        cycles++;
    end
    check_equal(test_name, "bytes at config_done", 32'(NUM_BYTES), 32'(got_q.size()));
endtask

task automatic compare_stream(input string test_name);
    check_equal(test_name, "request count", 32'(NUM_BYTES), 32'(got_q.size()));
    for (int i = 0; i < NUM_BYTES; i++) begin
        check_equal(test_name, $sformatf("entry %0d byte %0d", i / 4, i % 4),
                    32'(expected_xfer(i / 4, i % 4)), 32'(got_q[i]));
    end
endtask

task automatic test_reset_powerup();
    random_delay = 1'b0;
    inject_extra = 1'b0;
    apply_reset("reset_powerup");
    wait_first_req("reset_powerup");
endtask

task automatic test_byte_framing();
    wait_config_done("byte_framing", SEQ_CYCLES);
    compare_stream("byte_framing");
endtask

task automatic test_completion();
    repeat (500) begin
        next_cycle();
        check_equal("completion", "config_done level", 32'd1, 32'(config_done));
        check_equal("completion", "req after done", 32'd0, 32'(req));
        check_equal("completion", "xfer after done", 32'd0, 32'(xfer));
    end
    check_equal("completion", "request count", 32'(NUM_BYTES), 32'(got_q.size()));
endtask

task automatic test_random_latency();
    random_delay = 1'b1;
    inject_extra = 1'b1;
    apply_reset("random_latency");
    wait_first_req("random_latency");
    wait_config_done("random_latency", SEQ_CYCLES);
    compare_stream("random_latency");
endtask

task automatic test_reset_midway();
    int reqs;
    int cycles;
    random_delay = 1'b0;
    inject_extra = 1'b0;
    apply_reset("reset_midway");
    wait_first_req("reset_midway");
    reqs   = 1;
    cycles = 0;
    while (reqs < MID_REQS) begin
        if (cycles == SEQ_CYCLES) begin
            fail_now("reset_midway: sequence stalled before the reset point");
        end
        next_cycle();
        cycles++;
        if (req) begin
            reqs++;
        end
    end
    check_equal("reset_midway", "config_done before reset", 32'd0, 32'(config_done));
    rst_n = 1'b0;                                    // Asserted while req is high
    #1;
    check_equal("reset_midway", "req at reset assert", 32'd0, 32'(req));
    check_equal("reset_midway", "xfer at reset assert", 32'd0, 32'(xfer));
    apply_reset("reset_midway");
    wait_first_req("reset_midway");
    wait_config_done("reset_midway", SEQ_CYCLES);
    compare_stream("reset_midway");                  // Must restart at entry 0
endtask

`endif

//--- tb_cam_config.sv
`default_nettype none
`include "cam_cfg.svh"

module tb_cam_config
    import cam_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 8;
    localparam int POWERUP      = `CAM_POWERUP_CYCLES;
    localparam int SEQ_CYCLES   = 20000;       // Budget for one full table pass
    localparam int NUM_TESTS    = 5;
    localparam int NUM_RESETS   = 4;           // Resets that restart the power-up wait
    localparam int WATCHDOG_CYCLES = NUM_RESETS * (RESET_CYCLES + POWERUP)
                                   + NUM_TESTS * SEQ_CYCLES;
    localparam int NUM_BYTES    = 4 * `CAM_REG_NUM;
    localparam int MID_REQS     = 4 * 20 + 2;  // Lands inside entry 20

    // Register writes the sensor must receive, address and value
    localparam logic [23:0] EXP_TABLE [`CAM_REG_NUM] = '{
        24'h3103_11, 24'h3008_82, 24'h3008_42, 24'h3103_03, 24'h3017_ff, 24'h3018_ff,
        24'h3034_1a, 24'h3037_13, 24'h3108_01, 24'h302d_60, 24'h3810_00, 24'h3811_10,
        24'h3812_00, 24'h3000_00, 24'h3004_ff, 24'h300e_58, 24'h302e_00, 24'h4300_61,
        24'h501f_01, 24'h440e_00, 24'h3008_02, 24'h3035_21, 24'h3036_69, 24'h3820_47,
        24'h3821_01, 24'h3814_31, 24'h3815_31, 24'h3800_00, 24'h3801_00, 24'h3802_00,
        24'h3803_fa, 24'h3804_0a, 24'h3805_3f, 24'h3806_06, 24'h3807_a9, 24'h3808_05,
        24'h3809_00, 24'h380a_02, 24'h380b_d0, 24'h380c_07, 24'h380d_64, 24'h380e_02,
        24'h380f_e4, 24'h3813_04, 24'h3824_04, 24'h4740_20, 24'h503d_00, 24'h4741_00
    };

    logic       clk;
    logic       rst_n;
    logic       done;
    logic       req;
    sccb_xfer_t xfer;
    logic       config_done;

    sccb_xfer_t got_q[$];      // Every byte the master model accepted
    integer     seed;
    logic       random_delay;  // Random done latency, else one cycle
    logic       inject_extra;  // Stray done after each stop byte
    logic       busy;
    logic       cur_stop;
    logic       extra_pending;
    int         wait_cnt;

    cam_config u_cam_config (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .req         (req),
        .xfer        (xfer),
        .config_done (config_done)
    );

    `include "tb_cam_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Byte master model, one done per req
    initial begin
        done          = 1'b0;
        busy          = 1'b0;
        cur_stop      = 1'b0;
        extra_pending = 1'b0;
        wait_cnt      = 0;
        forever begin
            @(posedge clk);
            #1;
            done = 1'b0;
            if (!rst_n) begin
                busy          = 1'b0;
                extra_pending = 1'b0;
            end else if (busy) begin
                if (req) begin
                    fail_now("req rose while a byte was still outstanding at the master");
                end
                if (wait_cnt == 0) begin
                    done          = 1'b1;
                    busy          = 1'b0;
                    extra_pending = cur_stop && inject_extra;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end else if (req) begin
                got_q.push_back(xfer);
                cur_stop = xfer.cmd.stop;
                wait_cnt = pick_delay();
                if (wait_cnt == 0) begin
                    done          = 1'b1;            // Answer in the request cycle
                    extra_pending = cur_stop && inject_extra;
                end else begin
                    wait_cnt = wait_cnt - 1;
                    busy     = 1'b1;
                end
            end else if (extra_pending) begin
                done          = 1'b1;                // Nothing outstanding here
                extra_pending = 1'b0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now("Watchdog expired before all tests finished");
    end

    initial begin
        seed         = 32'h973e3fbe;
        rst_n        = 1'b0;
        random_delay = 1'b0;
        inject_extra = 1'b0;
        test_reset_powerup();
        test_byte_framing();
        test_completion();
        test_random_latency();
        test_reset_midway();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
cam_pkg.sv
cam_reg_rom.sv
cam_power_wait.sv
cam_config_seq.sv
cam_config.sv
tb_cam_config.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f project.f --top-module tb_cam_config \
    --Mdir obj_dir -o tb_cam_config

./obj_dir/tb_cam_config > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
